// ==== hdl/periph_config.svh ====
////////////////////////////////////////////////////////////////////////////
// Build constants for the peripheral subsystem
// The UART divider is fixed at elaboration, so the baud rate cannot change at run time
// FCLK must be a near multiple of BAUD or the sampling point drifts
////////////////////////////////////////////////////////////////////////////
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

`define FCLK            1152000     // System clock in Hz
`define BAUD            115200
`define UART_DIVIDER    ((`FCLK + `BAUD / 2) / `BAUD)   // Rounded, 10 here

`define PWM_TOP         180         // Counter runs 0..180

// Register byte offsets
`define OFS_UART_DATA   8'h00
`define OFS_UART_STAT   8'h04
`define OFS_PWM         8'h20
`define OFS_TIMER       8'h60
`define OFS_IRQEN       8'hE0

`define ADDR_BITS       8
`endif

// ==== hdl/periphPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared types for the register bus and the interrupt logic
// The address type follows ADDR_BITS from the build constants
////////////////////////////////////////////////////////////////////////////
`include "periph_config.svh"

package periphPkg;

	// Register byte address
	typedef logic [`ADDR_BITS-1:0] busAddr_t;

	// UART and PWM payload
	typedef logic [7:0] dataByte_t;

	// Host read and write data
	typedef logic [31:0] busWord_t;

	// Active source number
	// 0 none, 1 RX, 2 TX, 3 PWM
	typedef logic [1:0] irqId_t;

	// Enable mask
	// Bit 0 RX, bit 1 TX, bit 2 PWM
	typedef logic [2:0] irqEn_t;

endpackage

// ==== hdl/uartIf.sv ====
////////////////////////////////////////////////////////////////////////////
// UART register traffic between the register block and the UART
// txWrite and rxRead are one-cycle strobes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "periph_config.svh"

interface uartIf;
	import periphPkg::*;

	dataByte_t txData;  // Byte to send
	logic txWrite;      // Load strobe
	logic rxRead;       // Clears valid and overrun
	dataByte_t rxData;  // Last received byte
	logic txRdy;
	logic rxValid;
	logic rxOverrun;
	logic rxFrameErr;   // Stop bit was low

	// Register block side
	modport regs (output txData, txWrite, rxRead,
		input rxData, txRdy, rxValid, rxOverrun, rxFrameErr);

	// UART side
	modport uart (input txData, txWrite, rxRead,
		output rxData, txRdy, rxValid, rxOverrun, rxFrameErr);
endinterface

// ==== hdl/uartCore.sv ====
////////////////////////////////////////////////////////////////////////////
// Fixed-rate UART, 8N1 only
// A write while txRdy is low restarts the frame, the register block waits
// The receiver resyncs its bit timer on every rxd edge
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "periph_config.svh"

module uartCore (
	input logic clk,
	input logic reset,
	uartIf.uart bus,
	input logic rxd,            // Serial in
	output logic txd            // Serial out, idle high
);
	localparam int DIVIDER = `UART_DIVIDER;
	localparam int DBITS = $clog2(DIVIDER);

	logic [DBITS-1:0] txDiv;    // TX bit timer
	logic txDivMax;
	logic [8:0] txShift;        // Data plus start bit
	logic [3:0] txBitCnt;       // Bits left, 0 when idle
	logic [1:0] rxSync;         // Two-stage synchroniser
	logic rxEdge;
	logic [DBITS-1:0] rxDiv;    // RX bit timer
	logic rxSample;
	logic [9:0] rxShift;        // Start bit walks down to bit 0
	logic rxDone;
	logic [8:0] rxBuffer;       // Stop bit and data
	logic [1:0] rxFlags;        // Overrun, valid

	//////////////////////////////////////////////////////////////////////////
	// Transmitter
	assign txDivMax = (txDiv == DBITS'(DIVIDER - 1));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			txDiv <= '0;
		end else if (bus.txWrite || txDivMax) begin
			txDiv <= '0;            // Restart on load, bit edge at max
		end else begin
			txDiv <= txDiv + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			txShift <= '1;
			txBitCnt <= '0;
		end else if (bus.txWrite) begin
			txShift <= {bus.txData, 1'b0};  // Start bit first
			txBitCnt <= 4'd10;
		end else if (txDivMax) begin
			txShift <= {1'b1, txShift[8:1]};  // Ones fill in for the stop bit
			if (txBitCnt != '0)
				txBitCnt <= txBitCnt - 1'b1;
		end
	end

	assign txd = txShift[0];
	assign bus.txRdy = (txBitCnt == '0);

	//////////////////////////////////////////////////////////////////////////
	// Receiver
	assign rxEdge = rxSync[1] ^ rxSync[0];
	assign rxSample = (rxDiv == DBITS'(DIVIDER / 2 - 1));  // Mid-bit
	assign rxDone = ~rxShift[0];    // Start bit has reached the bottom

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxSync <= 2'b11;        // Line idles high
			rxDiv <= '0;
		end else begin
			rxSync <= {rxSync[0], rxd};
			if (rxEdge || rxDiv == DBITS'(DIVIDER - 1))
				rxDiv <= '0;
			else
				rxDiv <= rxDiv + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxShift <= '1;
			rxBuffer <= 9'h100;     // Stop bit high, so no framing error
			rxFlags <= '0;
		end else if (rxDone) begin
			rxShift <= '1;          // Rearm for the next frame
			rxBuffer <= rxShift[9:1];
			rxFlags <= {rxFlags[0], 1'b1};  // Valid, overrun if still valid
		end else begin
			if (rxSample)
				rxShift <= {rxSync[1], rxShift[9:1]};
			if (bus.rxRead)
				rxFlags <= '0;
		end
	end

	assign bus.rxData = rxBuffer[7:0];
	assign bus.rxFrameErr = ~rxBuffer[8];
	assign bus.rxValid = rxFlags[0];
	assign bus.rxOverrun = rxFlags[1];
endmodule

// ==== hdl/pwmGen.sv ====
////////////////////////////////////////////////////////////////////////////
// PWM with a period of PWM_TOP+1 cycles
// A new duty takes effect at the next terminal count
// Duty above PWM_TOP keeps the output high for the whole period
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "periph_config.svh"

module pwmGen (
	input logic clk,
	input logic reset,
	input logic dutyWrite,          // Also clears the interrupt
	input periphPkg::dataByte_t duty,
	output logic pwmOut,
	output logic pwmIrq             // Set at each period start
);
	import periphPkg::*;

	logic [7:0] count;
	logic termCount;
	logic zeroCount;
	dataByte_t dutyPend;            // Written by the host
	dataByte_t dutyBuf;             // Used by the compare

	assign termCount = (count == 8'(`PWM_TOP));
	assign zeroCount = (count == '0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
			dutyPend <= '0;
			dutyBuf <= '0;
			pwmOut <= 1'b0;
			pwmIrq <= 1'b0;
		end else begin
			count <= termCount ? '0 : count + 1'b1;
			if (dutyWrite)
				dutyPend <= duty;
			if (termCount)
				dutyBuf <= dutyPend;    // Double buffer, no glitch mid-period
			// Compare wins over the set, so duty 0 stays low
			pwmOut <= (count == dutyBuf) ? 1'b0 : (zeroCount ? 1'b1 : pwmOut);
			pwmIrq <= zeroCount ? 1'b1 : (dutyWrite ? 1'b0 : pwmIrq);
		end
	end
endmodule

// ==== hdl/periphRegs.sv ====
////////////////////////////////////////////////////////////////////////////
// Register block on a four-phase req/ack bus
// UART data accesses hold ack back until the UART is ready
// The host must keep addr, write and wdata stable while req is high
// Only wdata[7:0] is used by the byte registers
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "periph_config.svh"

module periphRegs (
	input logic clk,
	input logic reset,
	input logic req,
	input logic write,
	input periphPkg::busAddr_t addr,
	input periphPkg::busWord_t wdata,
	output periphPkg::busWord_t rdata,  // Valid while ack is high
	output logic ack,
	output logic irq,
	output periphPkg::irqId_t irqId,
	uartIf.regs uart,
	output logic dutyWrite,
	output periphPkg::dataByte_t duty,
	input logic pwmIrq
);
	import periphPkg::*;

	typedef enum logic [1:0] {
		IDLE,       // Waiting for req
		BUSY,       // Access seen, waiting for ready
		DONE        // Ack high until req drops
	} busState_t;

	busState_t state;
	logic selData;
	logic selStat;
	logic selPwm;
	logic selTimer;
	logic selIrqEn;
	logic ready;                    // Access may complete this cycle
	logic complete;                 // Cycle in which the access takes effect
	busWord_t readWord;
	busWord_t timer;                // Free-running cycle count
	irqEn_t irqEn;
	irqEn_t pending;

	//////////////////////////////////////////////////////////////////////////
	// Decode and handshake
	assign selData = (addr == `OFS_UART_DATA);
	assign selStat = (addr == `OFS_UART_STAT);
	assign selPwm = (addr == `OFS_PWM);
	assign selTimer = (addr == `OFS_TIMER);
	assign selIrqEn = (addr == `OFS_IRQEN);

	// Back-pressure from the UART
	assign ready = selData ? (write ? uart.txRdy : uart.rxValid) : 1'b1;
	assign complete = (state == BUSY) && ready;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			ack <= 1'b0;
		end else begin
			case (state)
				IDLE: if (req) state <= BUSY;
				BUSY: if (ready) begin
					state <= DONE;
					ack <= 1'b1;
				end
				DONE: if (!req) begin
					state <= IDLE;
					ack <= 1'b0;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Strobes only in the completing cycle
	assign uart.txWrite = complete && selData && write;
	assign uart.rxRead = complete && selData && !write;
	assign uart.txData = wdata[7:0];
	assign dutyWrite = complete && selPwm && write;
	assign duty = wdata[7:0];

	//////////////////////////////////////////////////////////////////////////
	// Read path
	always_comb begin
		readWord = '0;              // Unmapped reads give zero
		if (selData)
			readWord = {24'b0, uart.rxData};
		else if (selStat)
			readWord = {27'b0, pwmIrq, uart.rxOverrun, uart.rxFrameErr,
				uart.txRdy, uart.rxValid};
		else if (selTimer)
			readWord = timer;
		else if (selIrqEn)
			readWord = {29'b0, irqEn};
	end

	always_ff @(posedge clk) begin
		if (complete && !write)
			rdata <= readWord;      // Held while ack is high
	end

	//////////////////////////////////////////////////////////////////////////
	// Timer and irq enable
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			timer <= '0;
			irqEn <= '0;
		end else begin
			timer <= timer + 1'b1;
			if (complete && selIrqEn && write)
				irqEn <= wdata[2:0];
		end
	end

	// Fixed priority, RX first
	assign pending = irqEn & {pwmIrq, uart.txRdy, uart.rxValid};
	assign irq = |pending;

	always_comb begin
		if (pending[0])
			irqId = 2'd1;
		else if (pending[1])
			irqId = 2'd2;
		else if (pending[2])
			irqId = 2'd3;
		else
			irqId = 2'd0;
	end
endmodule

// ==== hdl/periphTop.sv ====
////////////////////////////////////////////////////////////////////////////
// Peripheral subsystem top, UART, PWM, timer and irq control
// Everything runs on clk, reset is asynchronous and active high
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module periphTop (
	input logic clk,
	input logic reset,
	input logic req,                    // Host bus
	input logic write,
	input periphPkg::busAddr_t addr,
	input periphPkg::busWord_t wdata,
	output periphPkg::busWord_t rdata,
	output logic ack,
	input logic rxd,                    // Serial line
	output logic txd,
	output logic pwmOut,
	output logic irq,
	output periphPkg::irqId_t irqId
);
	import periphPkg::*;

	logic dutyWrite;
	dataByte_t duty;
	logic pwmIrq;

	uartIf uartBus ();                  // Register block to UART

	periphRegs regBlock (
		.clk(clk), .reset(reset),
		.req(req), .write(write), .addr(addr), .wdata(wdata),
		.rdata(rdata), .ack(ack),
		.irq(irq), .irqId(irqId),
		.uart(uartBus.regs),
		.dutyWrite(dutyWrite), .duty(duty), .pwmIrq(pwmIrq)
	);

	uartCore uartUnit (
		.clk(clk), .reset(reset),
		.bus(uartBus.uart),
		.rxd(rxd), .txd(txd)
	);

	pwmGen pwm (
		.clk(clk), .reset(reset),
		.dutyWrite(dutyWrite), .duty(duty),
		.pwmOut(pwmOut), .pwmIrq(pwmIrq)
	);
endmodule

// ==== tests/periphTb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the peripheral subsystem, txd looped back into rxd
// Inputs change on the falling edge and outputs are sampled there as well
// The first failed check ends the run, a watchdog bounds the total time
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "periph_config.svh"

module periphTb;
	import periphPkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int FRAME_CYCLES = 10 * `UART_DIVIDER;   // Start, 8 data, stop
	localparam int PERIOD_CYCLES = `PWM_TOP + 1;
	localparam int WATCHDOG_CYCLES = 20 * FRAME_CYCLES + 4 * PERIOD_CYCLES;

	// Status register bits
	localparam busWord_t RX_VALID = 32'h01;
	localparam busWord_t TX_RDY = 32'h02;
	localparam busWord_t FRAME_ERR = 32'h04;
	localparam busWord_t OVERRUN = 32'h08;

	logic clk;
	logic reset;
	logic req;
	logic write;
	busAddr_t addr;
	busWord_t wdata;
	busWord_t rdata;
	logic ack;
	logic txd;                      // Also feeds rxd
	logic pwmOut;
	logic irq;
	irqId_t irqId;

	integer seed;
	int lastWait;                   // Cycles from req to ack in the last access
	int highCycles;
	busWord_t word;
	busWord_t prevTimer;
	dataByte_t txByte;
	dataByte_t txByte2;
	dataByte_t dutyVal;

	periphTop uut (
		.clk(clk), .reset(reset),
		.req(req), .write(write), .addr(addr), .wdata(wdata),
		.rdata(rdata), .ack(ack),
		.rxd(txd), .txd(txd),       // Loopback
		.pwmOut(pwmOut), .irq(irq), .irqId(irqId)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////////
	// Failure reporting
	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic checkFailed(input string what);
		abortRun($sformatf("** Error at %0t ns: %s", $time, what));
	endtask

	//////////////////////////////////////////////////////////////////////////
	// Four-phase bus access, returns at a falling edge with ack low
	task automatic busAccess(input logic isWrite, input busAddr_t a, input busWord_t d,
		output busWord_t q);
		@(negedge clk);
		assert (!ack) else checkFailed("ack high before req was raised");
		req = 1'b1;
		write = isWrite;
		addr = a;
		wdata = d;
		@(negedge clk);
		lastWait = 1;
		while (!ack) begin          // Host just holds req under back-pressure
			@(negedge clk);
			lastWait++;
		end
		q = rdata;                  // Valid while ack is high
		req = 1'b0;
		while (ack)
			@(negedge clk);
	endtask

	task automatic writeReg(input busAddr_t a, input busWord_t d);
		busWord_t unusedData;
		busAccess(1'b1, a, d, unusedData);
	endtask

	task automatic readReg(input busAddr_t a, output busWord_t q);
		busAccess(1'b0, a, '0, q);
	endtask

	// Poll status until every bit in mask is set
	task automatic waitStatus(input busWord_t mask);
		busWord_t stat;
		readReg(`OFS_UART_STAT, stat);
		while ((stat & mask) != mask)
			readReg(`OFS_UART_STAT, stat);
	endtask

	// Returns at the first falling edge that sees pwmOut newly high
	task automatic waitPwmRise();
		logic prev;
		prev = pwmOut;
		@(negedge clk);
		while (!(pwmOut && !prev)) begin
			prev = pwmOut;
			@(negedge clk);
		end
	endtask

	//////////////////////////////////////////////////////////////////////////
	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abortRun("Timeout: the tests did not finish within the watchdog time");
	end

	initial begin
		seed = 47609;
		clk = 1'b0;
		reset = 1'b1;
		req = 1'b0;
		write = 1'b0;
		addr = '0;
		wdata = '0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		// Reset state
		assert (!ack && !irq && !pwmOut) else checkFailed("ack, irq or pwmOut high after reset");
		assert (irqId == 2'd0) else checkFailed($sformatf("irqId %0d after reset", irqId));
		assert (txd) else checkFailed("txd low after reset");
		readReg(`OFS_UART_STAT, word);
		assert (word[3:0] == 4'b0010)
			else checkFailed($sformatf("status 0x%02h after reset", word[7:0]));
		assert (word[4]) else checkFailed("pwmIrq not set by the first period start");
		readReg(`OFS_TIMER, prevTimer);
		assert (prevTimer != 0) else checkFailed("timer still zero");
		readReg(`OFS_TIMER, word);
		assert (word > prevTimer)
			else checkFailed($sformatf("timer 0x%08h not above 0x%08h", word, prevTimer));
		readReg(8'h10, word);       // Unmapped
		assert (word == 0) else checkFailed($sformatf("unmapped read gave 0x%08h", word));

		// Loopback, the read waits for the whole frame
		txByte = 8'($random(seed));
		writeReg(`OFS_UART_DATA, {24'b0, txByte});
		readReg(`OFS_UART_DATA, word);
		assert (lastWait > 9 * `UART_DIVIDER)
			else checkFailed($sformatf("data read acked after only %0d cycles", lastWait));
		assert (word[7:0] == txByte)
			else checkFailed($sformatf("rx 0x%02h, expected 0x%02h", word[7:0], txByte));
		readReg(`OFS_UART_STAT, word);
		assert ((word & (RX_VALID | FRAME_ERR | OVERRUN)) == 0)
			else checkFailed($sformatf("status 0x%02h after data read", word[7:0]));

		// Overrun, second write is held off until the first frame is out
		txByte = 8'($random(seed));
		txByte2 = 8'($random(seed));
		writeReg(`OFS_UART_DATA, {24'b0, txByte});
		writeReg(`OFS_UART_DATA, {24'b0, txByte2});
		waitStatus(TX_RDY);
		readReg(`OFS_UART_STAT, word);
		assert ((word & (RX_VALID | OVERRUN)) == (RX_VALID | OVERRUN))
			else checkFailed($sformatf("status 0x%02h, expected valid and overrun", word[7:0]));
		readReg(`OFS_UART_DATA, word);
		assert (word[7:0] == txByte2)
			else checkFailed($sformatf("rx 0x%02h, expected 0x%02h", word[7:0], txByte2));
		readReg(`OFS_UART_STAT, word);
		assert ((word & (RX_VALID | FRAME_ERR | OVERRUN)) == 0)
			else checkFailed($sformatf("status 0x%02h after overrun read", word[7:0]));

		// PWM duty over one full period
		dutyVal = 8'(1 + ({$random(seed)} % `PWM_TOP));
		writeReg(`OFS_PWM, {24'b0, dutyVal});
		waitPwmRise();              // New duty is buffered by now
		waitPwmRise();
		highCycles = 0;
		repeat (PERIOD_CYCLES) begin
			if (pwmOut)
				highCycles++;
			@(negedge clk);
		end
		assert (highCycles == int'(dutyVal))
			else checkFailed($sformatf("pwm high %0d cycles, expected %0d", highCycles, dutyVal));

		// RX interrupt only
		writeReg(`OFS_IRQEN, 32'h1);
		readReg(`OFS_IRQEN, word);
		assert (word == 32'h1) else checkFailed($sformatf("irq enable reads 0x%08h", word));
		assert (!irq) else checkFailed("irq high with nothing received");
		txByte = 8'($random(seed));
		writeReg(`OFS_UART_DATA, {24'b0, txByte});
		while (!irq)
			@(negedge clk);
		assert (irqId == 2'd1) else checkFailed($sformatf("irqId %0d, expected 1", irqId));
		readReg(`OFS_UART_DATA, word);
		assert (word[7:0] == txByte)
			else checkFailed($sformatf("rx 0x%02h, expected 0x%02h", word[7:0], txByte));
		assert (!irq) else checkFailed("irq still high after the data read");

		// TX outranks PWM
		waitStatus(TX_RDY);
		writeReg(`OFS_IRQEN, 32'h6);
		assert (irq && irqId == 2'd2)
			else checkFailed($sformatf("irq %b irqId %0d, expected TX", irq, irqId));

		// PWM only, flag cleared early in a period so the next one sets it again
		writeReg(`OFS_IRQEN, 32'h4);
		waitPwmRise();
		writeReg(`OFS_PWM, {24'b0, dutyVal});
		assert (!irq) else checkFailed("duty write did not clear the PWM interrupt");
		while (!irq)
			@(negedge clk);
		assert (irqId == 2'd3) else checkFailed($sformatf("irqId %0d, expected 3", irqId));
		assert (pwmOut) else checkFailed("PWM interrupt rose away from the period start");
		writeReg(`OFS_PWM, {24'b0, dutyVal});
		assert (!irq) else checkFailed("irq still high after the duty write");

		$display("Simulation finished: PASS");
		$finish;
	end
endmodule

// ==== build.f ====
+incdir+hdl
hdl/periphPkg.sv
hdl/uartIf.sv
hdl/uartCore.sv
hdl/pwmGen.sv
hdl/periphRegs.sv
hdl/periphTop.sv
tests/periphTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = periphTb
FILELIST  = build.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

# Verdict comes from the log, not from the exit status of the run
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
